//--- rvCore.f
rtl/rvPkg.sv
rtl/pcUnit.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/loadWriteback.sv
rtl/rvCore.sv
dv/clkGen.sv
dv/rvCoreTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module rvCoreTb \
	--Mdir obj_dir \
	-f rvCore.f

out=$(./obj_dir/VrvCoreTb)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- dv/rvCoreTb.sv
`default_nettype none
`timescale 1ns/1ns

module rvCoreTb;
	import rvPkg::*;

	localparam int          maxRows     = 96;
	localparam int          haltTimeout = 20;
	localparam logic [31:0] nop         = 32'h0000_0013; // addi x0,x0,0
	localparam logic [31:0] ebreak      = 32'h0010_0073;
	localparam logic [6:0]  chkPc       = 7'b0000001;
	localparam logic [6:0]  chkAlu      = 7'b0000010;
	localparam logic [6:0]  chkMemWr    = 7'b0000100;
	localparam logic [6:0]  chkLen      = 7'b0001000;
	localparam logic [6:0]  chkStore    = 7'b0010000;
	localparam logic [6:0]  chkInv      = 7'b0100000;
	localparam logic [6:0]  chkMemRd    = 7'b1000000;
	localparam logic [6:0]  chkBasic    = chkPc | chkMemWr | chkMemRd | chkInv;

	logic            clk;
	logic            rstN;
	logic [xlen-1:0] inst;
	logic [xlen-1:0] readData;
	logic [xlen-1:0] pc;
	logic [xlen-1:0] aluResult;
	logic [xlen-1:0] storeData;
	memSizeT         dataLen;
	logic            memWrite;
	logic            memRead;
	logic            invalid;
	logic            halt;

	// program table with one row per cycle
	logic [31:0] rowInst  [maxRows];
	logic [31:0] rowData  [maxRows];
	logic [31:0] rowPc    [maxRows];
	logic [31:0] rowAlu   [maxRows];
	logic [31:0] rowStore [maxRows];
	logic [1:0]  rowLen   [maxRows];
	logic        rowMemWr [maxRows];
	logic        rowMemRd [maxRows];
	logic        rowInv   [maxRows];
	logic [6:0]  rowMask  [maxRows];
	int          nRows;

	logic [31:0] xr [32]; // architectural registers as the ISA sees them
	logic [31:0] mpc;
	int          seed = 32'hf5;
	int          errors;
	int          checks;
	int          waited;

	clkGen #(.periodNs(8)) clkGen_i (.clk);

	rvCore #(.resetPc(32'h0), .nRegs(32)) rvCore_i (
		.clk, .rstN, .inst, .readData, .pc, .aluResult, .storeData,
		.dataLen, .memWrite, .memRead, .invalid, .halt
	);

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, opReg};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opBranch};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, opJal};
	endfunction

	// RV32I result by funct3 and funct7 bit 5
	function automatic logic [31:0] isaAlu(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		logic signed [31:0] sa;
		sa = a;
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) return sa >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic pushRow(input logic [31:0] word, input logic [31:0] rdata,
			input logic [31:0] alu, input logic [1:0] len, input logic [31:0] sdata,
			input logic memWr, input logic memRd, input logic inv, input logic [6:0] mask);
		rowInst[nRows]  = word;
		rowData[nRows]  = rdata;
		rowPc[nRows]    = mpc;
		rowAlu[nRows]   = alu;
		rowLen[nRows]   = len;
		rowStore[nRows] = sdata;
		rowMemWr[nRows] = memWr;
		rowMemRd[nRows] = memRd;
		rowInv[nRows]   = inv;
		rowMask[nRows]  = mask;
		nRows++;
		mpc = mpc + 32'd4;
	endtask

	task automatic writeModelReg(input logic [4:0] rd, input logic [31:0] value);
		if (rd != 5'd0) xr[rd] = value;
	endtask

	task automatic regRegOp(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		logic [31:0] res;
		res = isaAlu(f3, f7[5], xr[rs1], xr[rs2]);
		pushRow(rType(f7, f3, rd, rs1, rs2), '0, res, 2'd0, '0, 1'b0, 1'b0, 1'b0,
			chkBasic | chkAlu);
		writeModelReg(rd, res);
	endtask

	task automatic regImmOp(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		logic [31:0] res;
		res = isaAlu(f3, 1'b0, xr[rs1], sext12(imm));
		pushRow(iType(imm, rs1, f3, rd, opImm), '0, res, 2'd0, '0, 1'b0, 1'b0, 1'b0,
			chkBasic | chkAlu);
		writeModelReg(rd, res);
	endtask

	task automatic loadUpper(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = {value[31:12], 12'b0};
		pushRow({upper[31:12], rd, opLui}, '0, upper, 2'd0, '0, 1'b0, 1'b0, 1'b0,
			chkBasic | chkAlu);
		writeModelReg(rd, upper);
	endtask

	task automatic addUpperToPc(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] res;
		res = mpc + {value[31:12], 12'b0};
		pushRow({value[31:12], rd, opAuipc}, '0, '0, 2'd0, '0, 1'b0, 1'b0, 1'b0, chkBasic);
		writeModelReg(rd, res);
	endtask

	task automatic exposeReg(input logic [4:0] rs);
		regImmOp(3'd0, 5'd0, rs, 12'd0); // addi x0,rs,0
	endtask

	task automatic setConst(input logic [4:0] rd, input logic [31:0] value);
		loadUpper(rd, value + 32'h800); // low part is added back sign extended
		regImmOp(3'd0, rd, rd, value[11:0]);
	endtask

	task automatic writeMem(input logic [2:0] f3, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [11:0] off);
		pushRow(sType(off, rs2, rs1, f3), '0, xr[rs1] + sext12(off), f3[1:0], xr[rs2],
			1'b1, 1'b0, 1'b0, chkBasic | chkAlu | chkLen | chkStore);
	endtask

	task automatic readMem(input logic [2:0] f3, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] off, input logic [31:0] rdata);
		logic [31:0] ext;
		case (f3)
			3'd0: ext = {{24{rdata[7]}}, rdata[7:0]};
			3'd1: ext = {{16{rdata[15]}}, rdata[15:0]};
			3'd4: ext = {24'b0, rdata[7:0]};
			3'd5: ext = {16'b0, rdata[15:0]};
			default: ext = rdata;
		endcase
		pushRow(iType(off, rs1, f3, rd, opLoad), rdata, xr[rs1] + sext12(off), f3[1:0], '0,
			1'b0, 1'b1, 1'b0, chkBasic | chkAlu | chkLen);
		writeModelReg(rd, ext);
	endtask

	task automatic branchEq(input logic [4:0] rs1, input logic [4:0] rs2,
			input logic [12:0] off);
		logic [31:0] old;
		logic [31:0] diff;
		old = mpc;
		diff = xr[rs1] - xr[rs2];
		pushRow(bType(off, rs2, rs1, 3'b000), '0, diff, 2'd0, '0, 1'b0, 1'b0, 1'b0,
			chkBasic | chkAlu);
		if (diff == '0) mpc = old + {{19{off[12]}}, off};
	endtask

	task automatic jumpAndLink(input logic [4:0] rd, input logic [20:0] off);
		logic [31:0] old;
		old = mpc;
		pushRow(jType(off, rd), '0, '0, 2'd0, '0, 1'b0, 1'b0, 1'b0, chkBasic);
		writeModelReg(rd, old + 32'd4);
		mpc = old + {{11{off[20]}}, off};
	endtask

	task automatic jumpToReg(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] off);
		logic [31:0] old;
		logic [31:0] sum;
		old = mpc;
		sum = xr[rs1] + sext12(off);
		pushRow(iType(off, rs1, 3'b000, rd, opJalr), '0, sum, 2'd0, '0, 1'b0, 1'b0, 1'b0,
			chkBasic | chkAlu);
		writeModelReg(rd, old + 32'd4);
		mpc = {sum[31:1], 1'b0};
	endtask

	task automatic buildProgram();
		logic [31:0] v1;
		mpc = 32'h0;
		for (int r = 0; r < 32; r++) xr[r] = '0;
		v1 = $random(seed);
		setConst(5'd1, v1);
		setConst(5'd2, $random(seed));
		setConst(5'd3, $random(seed));
		setConst(5'd4, v1); // equal pair for the taken beq
		setConst(5'd8, 32'h0000_1000);
		for (int p = 0; p < 2; p++) begin
			for (int f3 = 0; f3 < 8; f3++) begin
				regRegOp(7'h00, 3'(f3), 5'(10 + f3), 5'(1 + 2 * p), 5'(2 - p));
			end
			regRegOp(7'h20, 3'd0, 5'd18, 5'(1 + 2 * p), 5'(2 - p)); // sub
			regRegOp(7'h20, 3'd5, 5'd19, 5'(1 + 2 * p), 5'(2 - p)); // sra
		end
		for (int f3 = 0; f3 < 8; f3++) begin
			if (f3 != 1 && f3 != 5) regImmOp(3'(f3), 5'(20 + f3), 5'd1, 12'($random(seed)));
		end
		addUpperToPc(5'd5, $random(seed));
		exposeReg(5'd5);
		loadUpper(5'd6, $random(seed));
		exposeReg(5'd6);
		for (int f3 = 0; f3 < 3; f3++) writeMem(3'(f3), 5'd2, 5'd8, 12'($random(seed)));
		for (int f3 = 0; f3 < 6; f3++) begin
			if (f3 != 3) begin
				readMem(3'(f3), 5'd9, 5'd8, 12'($random(seed)), $random(seed) | 32'h8080_8080);
				exposeReg(5'd9);
			end
		end
		branchEq(5'd1, 5'd4, 13'd16);
		branchEq(5'd1, 5'd2, 13'd16);
		jumpAndLink(5'd28, 21'h1ffff8); // backwards by 8
		exposeReg(5'd28);
		jumpToReg(5'd29, 5'd8, 12'd5); // odd sum so bit 0 gets cleared
		exposeReg(5'd29);
		pushRow(bType(13'd8, 5'd2, 5'd1, 3'b001), '0, '0, 2'd0, '0, 1'b0, 1'b0, 1'b1,
			chkBasic);
		pushRow(iType(12'd3, 5'd1, 3'b001, 5'd1, opImm), '0, '0, 2'd0, '0, 1'b0, 1'b0, 1'b1,
			chkBasic);
		exposeReg(5'd1); // slli must not have touched x1
	endtask

	initial begin
		rstN = 1'b0;
		inst = nop;
		readData = '0;
		errors = 0;
		checks = 0;
		nRows = 0;
		buildProgram();
		repeat (15) @(posedge clk);
		@(negedge clk);
		checkValue("pc in reset", pc, 32'h0);
		@(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < nRows; i++) begin
			inst <= rowInst[i];
			readData <= rowData[i];
			@(negedge clk);
			if ((rowMask[i] & chkPc) != 0) checkValue($sformatf("pc[%0d]", i), pc, rowPc[i]);
			if ((rowMask[i] & chkAlu) != 0) begin
				checkValue($sformatf("aluResult[%0d]", i), aluResult, rowAlu[i]);
			end
			if ((rowMask[i] & chkMemWr) != 0) begin
				checkValue($sformatf("memWrite[%0d]", i), {31'b0, memWrite}, {31'b0, rowMemWr[i]});
			end
			if ((rowMask[i] & chkMemRd) != 0) begin
				checkValue($sformatf("memRead[%0d]", i), {31'b0, memRead}, {31'b0, rowMemRd[i]});
			end
			if ((rowMask[i] & chkLen) != 0) begin
				checkValue($sformatf("dataLen[%0d]", i), {30'b0, dataLen}, {30'b0, rowLen[i]});
			end
			if ((rowMask[i] & chkStore) != 0) begin
				checkValue($sformatf("storeData[%0d]", i), storeData, rowStore[i]);
			end
			if ((rowMask[i] & chkInv) != 0) begin
				checkValue($sformatf("invalid[%0d]", i), {31'b0, invalid}, {31'b0, rowInv[i]});
			end
			@(posedge clk);
		end
		inst <= ebreak;
		readData <= '0;
		waited = 0;
		while (!halt && waited < haltTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (!halt) begin
			errors++;
			$display("timeout: halt did not rise after the ebreak word");
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/clkGen.sv
`default_nettype none
`timescale 1ns/1ns

module clkGen #(
	parameter int periodNs = 8
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- rtl/rvCore.sv
`default_nettype none
`timescale 1ns/1ns

module rvCore #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0,
	parameter int                     nRegs   = 32
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [rvPkg::xlen-1:0] inst,
	input  logic [rvPkg::xlen-1:0] readData,
	output logic [rvPkg::xlen-1:0] pc,
	output logic [rvPkg::xlen-1:0] aluResult,
	output logic [rvPkg::xlen-1:0] storeData,
	output rvPkg::memSizeT         dataLen,
	output logic                   memWrite,
	output logic                   memRead,
	output logic                   invalid,
	output logic                   halt
);
	import rvPkg::*;

	aluOpT           aluOp;
	wbSelT           wbSel;
	jmpT             jmp;
	memSizeT         memSize;
	logic            aluSrcImm;
	logic            regWrite;
	logic            memUnsigned;
	logic            branch;
	logic            zero;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rdata1;
	logic [xlen-1:0] rdata2;
	logic [xlen-1:0] aluB;
	logic [xlen-1:0] wbData;
	logic [xlen-1:0] pcPlus4;
	logic [xlen-1:0] pcTarget;
	regAddrT         rs1;
	regAddrT         rs2;
	regAddrT         rd;

	assign aluB      = aluSrcImm ? imm : rdata2;
	assign storeData = rdata2; // unshifted, memory uses dataLen
	assign dataLen   = memSize;

	pcUnit #(.resetPc(resetPc)) pcUnit_i (
		.clk, .rstN, .imm, .aluResult, .branch, .zero, .jmp,
		.pc, .pcPlus4, .pcTarget
	);

	instDecoder instDecoder_i (
		.inst, .aluOp, .wbSel, .jmp, .memSize, .aluSrcImm, .regWrite,
		.memWrite, .memRead, .memUnsigned, .branch, .invalid, .halt,
		.imm, .rs1, .rs2, .rd
	);

	regFile #(.nRegs(nRegs)) regFile_i (
		.clk, .rstN, .rs1, .rs2, .rd, .regWrite,
		.wdata(wbData),
		.rdata1, .rdata2
	);

	alu alu_i (
		.a(rdata1),
		.b(aluB),
		.aluOp,
		.result(aluResult),
		.zero
	);

	loadWriteback loadWriteback_i (
		.readData, .aluResult, .pcPlus4, .pcTarget,
		.memSize, .memUnsigned, .wbSel, .wbData
	);

endmodule

`default_nettype wire

//--- rtl/loadWriteback.sv
`default_nettype none
`timescale 1ns/1ns

module loadWriteback (
	input  logic [rvPkg::xlen-1:0] readData,
	input  logic [rvPkg::xlen-1:0] aluResult,
	input  logic [rvPkg::xlen-1:0] pcPlus4,
	input  logic [rvPkg::xlen-1:0] pcTarget,
	input  rvPkg::memSizeT         memSize,
	input  logic                   memUnsigned,
	input  rvPkg::wbSelT           wbSel,
	output logic [rvPkg::xlen-1:0] wbData
);
	import rvPkg::*;

	logic [xlen-1:0] loadData;
	logic            byteFill;
	logic            halfFill;

	assign byteFill = !memUnsigned && readData[7];
	assign halfFill = !memUnsigned && readData[15];

	always_comb begin
		case (memSize)
			sizeByte: loadData = {{24{byteFill}}, readData[7:0]};
			sizeHalf: loadData = {{16{halfFill}}, readData[15:0]};
			default:  loadData = readData;
		endcase
	end

	always_comb begin
		case (wbSel)
			wbMem:      wbData = loadData;
			wbPcPlus4:  wbData = pcPlus4;    // link for jal and jalr
			wbPcTarget: wbData = pcTarget;
			default:    wbData = aluResult;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none
`timescale 1ns/1ns

module alu (
	input  logic [rvPkg::xlen-1:0] a,
	input  logic [rvPkg::xlen-1:0] b,
	input  rvPkg::aluOpT           aluOp,
	output logic [rvPkg::xlen-1:0] result,
	output logic                   zero
);
	import rvPkg::*;

	logic [4:0] shamt;

	assign shamt = b[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:   result = a + b;
			aluSub:   result = a - b;
			aluSll:   result = a << shamt;
			aluSlt:   result = {31'b0, $signed(a) < $signed(b)};
			aluSltu:  result = {31'b0, a < b};
			aluXor:   result = a ^ b;
			aluSrl:   result = a >> shamt;
			aluSra:   result = $unsigned($signed(a) >>> shamt);
			aluOr:    result = a | b;
			aluAnd:   result = a & b;
			aluPassB: result = b;
			default:  result = '0;
		endcase
	end

	assign zero = result == '0; // beq compares through sub

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`default_nettype none
`timescale 1ns/1ns

module regFile #(
	parameter int nRegs = 32
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  rvPkg::regAddrT         rs1,
	input  rvPkg::regAddrT         rs2,
	input  rvPkg::regAddrT         rd,
	input  logic                   regWrite,
	input  logic [rvPkg::xlen-1:0] wdata,
	output logic [rvPkg::xlen-1:0] rdata1,
	output logic [rvPkg::xlen-1:0] rdata2
);
	import rvPkg::*;

	logic [xlen-1:0] regs [nRegs];

	// x0 and anything past nRegs read as zero
	assign rdata1 = (rs1 != '0 && int'(rs1) < nRegs) ? regs[rs1] : '0;
	assign rdata2 = (rs2 != '0 && int'(rs2) < nRegs) ? regs[rs2] : '0;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < nRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && rd != '0 && int'(rd) < nRegs) begin
			regs[rd] <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- rtl/instDecoder.sv
`default_nettype none
`timescale 1ns/1ns

module instDecoder (
	input  logic [rvPkg::xlen-1:0] inst,
	output rvPkg::aluOpT           aluOp,
	output rvPkg::wbSelT           wbSel,
	output rvPkg::jmpT             jmp,
	output rvPkg::memSizeT         memSize,
	output logic                   aluSrcImm,
	output logic                   regWrite,
	output logic                   memWrite,
	output logic                   memRead,
	output logic                   memUnsigned,
	output logic                   branch,
	output logic                   invalid,
	output logic                   halt,
	output logic [rvPkg::xlen-1:0] imm,
	output rvPkg::regAddrT         rs1,
	output rvPkg::regAddrT         rs2,
	output rvPkg::regAddrT         rd
);
	import rvPkg::*;

	localparam logic [xlen-1:0] ebreakWord = 32'h0010_0073;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [xlen-1:0] immI;
	logic [xlen-1:0] immS;
	logic [xlen-1:0] immB;
	logic [xlen-1:0] immU;
	logic [xlen-1:0] immJ;
	logic            legal;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];
	assign rd  = inst[11:7];

	assign immI = {{20{inst[31]}}, inst[31:20]};
	assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign immB = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	assign immU = {inst[31:12], 12'b0};
	assign immJ = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

	assign halt    = inst == ebreakWord;
	assign invalid = !legal;

	always_comb begin
		legal       = 1'b0;
		aluOp       = aluAdd;
		aluSrcImm   = 1'b0;
		regWrite    = 1'b0;
		wbSel       = wbAlu;
		memWrite    = 1'b0;
		memRead     = 1'b0;
		memSize     = sizeWord;
		memUnsigned = 1'b0;
		branch      = 1'b0;
		jmp         = jmpNone;
		imm         = immI;

		case (opcode)
			opLui: begin
				legal     = 1'b1;
				aluOp     = aluPassB;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				imm       = immU;
			end
			opAuipc: begin
				legal    = 1'b1;
				regWrite = 1'b1;
				wbSel    = wbPcTarget; // pc + imm comes from pcUnit
				imm      = immU;
			end
			opJal: begin
				legal    = 1'b1;
				regWrite = 1'b1;
				wbSel    = wbPcPlus4;
				jmp      = jmpJal;
				imm      = immJ;
			end
			opJalr: begin
				legal     = funct3 == 3'b000;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				wbSel     = wbPcPlus4;
				jmp       = jmpJalr;
			end
			opBranch: begin
				legal  = funct3 == 3'b000; // beq only
				aluOp  = aluSub;
				branch = 1'b1;
				imm    = immB;
			end
			opLoad: begin
				legal       = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
				aluSrcImm   = 1'b1;
				regWrite    = 1'b1;
				wbSel       = wbMem;
				memRead     = 1'b1;
				memSize     = memSizeT'(funct3[1:0]);
				memUnsigned = funct3[2];
			end
			opStore: begin
				legal     = funct3 inside {3'b000, 3'b001, 3'b010};
				aluSrcImm = 1'b1;
				memWrite  = 1'b1;
				memSize   = memSizeT'(funct3[1:0]);
				imm       = immS;
			end
			opImm: begin
				legal     = 1'b1;
				aluSrcImm = 1'b1;
				regWrite  = 1'b1;
				case (funct3)
					3'b000:  aluOp = aluAdd;
					3'b010:  aluOp = aluSlt;
					3'b011:  aluOp = aluSltu;
					3'b100:  aluOp = aluXor;
					3'b110:  aluOp = aluOr;
					3'b111:  aluOp = aluAnd;
					default: legal = 1'b0; // no shifts by immediate
				endcase
			end
			opReg: begin
				legal    = 1'b1;
				regWrite = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: aluOp = aluAdd;
					10'b0100000_000: aluOp = aluSub;
					10'b0000000_001: aluOp = aluSll;
					10'b0000000_010: aluOp = aluSlt;
					10'b0000000_011: aluOp = aluSltu;
					10'b0000000_100: aluOp = aluXor;
					10'b0000000_101: aluOp = aluSrl;
					10'b0100000_101: aluOp = aluSra;
					10'b0000000_110: aluOp = aluOr;
					10'b0000000_111: aluOp = aluAnd;
					default:         legal = 1'b0;
				endcase
			end
			opSystem: legal = inst == ebreakWord;
			default:  legal = 1'b0;
		endcase

		// an unknown word leaves registers, memory and pc flow alone
		if (!legal) begin
			regWrite = 1'b0;
			memWrite = 1'b0;
			memRead  = 1'b0;
			branch   = 1'b0;
			jmp      = jmpNone;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pcUnit.sv
`default_nettype none
`timescale 1ns/1ns

module pcUnit #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input  logic                   clk,
	input  logic                   rstN,
	input  logic [rvPkg::xlen-1:0] imm,
	input  logic [rvPkg::xlen-1:0] aluResult,
	input  logic                   branch,
	input  logic                   zero,
	input  rvPkg::jmpT             jmp,
	output logic [rvPkg::xlen-1:0] pc,
	output logic [rvPkg::xlen-1:0] pcPlus4,
	output logic [rvPkg::xlen-1:0] pcTarget
);
	import rvPkg::*;

	logic [xlen-1:0] pcNext;
	logic            takeTarget;

	assign pcPlus4  = pc + 32'd4;
	assign pcTarget = pc + imm; // jal, beq and auipc

	assign takeTarget = (jmp == jmpJal) || (branch && zero);

	always_comb begin
		if (jmp == jmpJalr) begin
			pcNext = {aluResult[xlen-1:1], 1'b0}; // rs1 + imm, bit 0 dropped
		end else if (takeTarget) begin
			pcNext = pcTarget;
		end else begin
			pcNext = pcPlus4;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

//--- rtl/rvPkg.sv
`default_nettype none

package rvPkg;

	localparam int xlen = 32;

	typedef logic [4:0] regAddrT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluSll,
		aluSlt,
		aluSltu,
		aluXor,
		aluSrl,
		aluSra,
		aluOr,
		aluAnd,
		aluPassB // lui
	} aluOpT;

	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbPcPlus4,
		wbPcTarget
	} wbSelT;

	typedef enum logic [1:0] {
		jmpNone,
		jmpJal,
		jmpJalr
	} jmpT;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		sizeByte = 2'd0,
		sizeHalf = 2'd1,
		sizeWord = 2'd2
	} memSizeT;

	// major opcodes, inst[6:0]
	localparam logic [6:0] opLui    = 7'b0110111;
	localparam logic [6:0] opAuipc  = 7'b0010111;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opImm    = 7'b0010011;
	localparam logic [6:0] opReg    = 7'b0110011;
	localparam logic [6:0] opSystem = 7'b1110011;

endpackage

`default_nettype wire
